//--- Makefile
# Verilator build and run of the D-cache testbench
TOP := tb_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass if the pass message is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- common/cache_pkg.sv
// D-cache geometry and fill FSM types for a 16-bit byte-addressed CPU
// Word offset is addr[3:1], set index addr[9:4], tag addr[15:10]
// The LRU state is one bit per set, so the design holds exactly two ways
package cache_pkg;

    // ------------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------------
    localparam int NUM_WAYS        = 2;
    localparam int SET_W           = 6;
    localparam int OFFSET_W        = 3;
    localparam int TAG_W           = 6;
    localparam int NUM_SETS        = 1 << SET_W;       // 64 sets
    localparam int WORDS_PER_BLOCK = 1 << OFFSET_W;    // 8 words per block
    localparam int SET_LSB         = OFFSET_W + 1;     // Bit 0 is the byte select
    localparam int TAG_LSB         = SET_LSB + SET_W;

    // Tag and valid for one way of one set
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } meta_t;

    // Block fill sequence
    typedef enum logic [1:0] {
        IDLE,       // No fill in progress
        FETCH,      // One word read issued per cycle
        DRAIN,      // Waiting on the last returns
        COMMIT      // Tag and valid written this cycle
    } fill_state_e;

endpackage

//--- common/dcache_array_if.sv
// Controller side of the D-cache tag, LRU and data arrays
// Reads are combinational from set and word; writes land on the clock edge
`timescale 1ns/10ps

interface dcache_array_if;

    // Lookup and write address
    logic [cache_pkg::SET_W-1:0]    set;
    logic [cache_pkg::OFFSET_W-1:0] word;

    // Data and metadata writes
    logic [mem_pkg::DATA_W-1:0]     wdata;
    logic [cache_pkg::NUM_WAYS-1:0] data_we;     // Per way
    logic [cache_pkg::NUM_WAYS-1:0] meta_we;     // Per way
    cache_pkg::meta_t               meta_in;     // Same value to any enabled way
    logic                           lru_we;
    logic                           lru_in;      // Way to evict next

    // Read side
    cache_pkg::meta_t [cache_pkg::NUM_WAYS-1:0]           meta_out;
    logic [cache_pkg::NUM_WAYS-1:0][mem_pkg::DATA_W-1:0]  data_out;
    logic                                                 lru_out;

    modport ctrl (
        output set, word, wdata, data_we, meta_we, meta_in, lru_we, lru_in,
        input  meta_out, data_out, lru_out
    );

    modport array (
        input  set, word, wdata, data_we, meta_we, meta_in, lru_we, lru_in,
        output meta_out, data_out, lru_out
    );

endinterface

//--- common/mem_bus_if.sv
// Main memory port between the cache controller and main memory
// A read returns rvalid exactly READ_LATENCY cycles after issue
// Writes complete in the issue cycle
`timescale 1ns/10ps

interface mem_bus_if;

    logic                       en;       // One access per cycle
    logic                       wr;       // Write-through when high
    logic [mem_pkg::ADDR_W-1:0] addr;     // Byte address
    logic [mem_pkg::DATA_W-1:0] wdata;
    logic [mem_pkg::DATA_W-1:0] rdata;    // Valid with rvalid
    logic                       rvalid;   // One pulse per returned read

    modport master (
        output en, wr, addr, wdata,
        input  rdata, rvalid
    );

    modport slave (
        input  en, wr, addr, wdata,
        output rdata, rvalid
    );

endinterface

//--- common/mem_pkg.sv
// Main memory bus widths and default timing
// Memory is word addressed through addr[15:1]; addr[0] is ignored
package mem_pkg;

    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 16;
    localparam int MEM_WORDS = 1 << (ADDR_W - 1);  // 32K words

    // Cycles from read issue to rvalid
    localparam int READ_LATENCY_DEF = 4;

endpackage

//--- dcache/dcache_arrays.sv
// Tag, valid, LRU and data storage of the two-way D-cache
// Reset clears valid and LRU bits only; tags and data keep their contents
`timescale 1ns/10ps

module dcache_arrays (
    input  logic          clk,
    input  logic          rst,
    dcache_array_if.array arr
);

    logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] valid_q;
    logic [cache_pkg::NUM_SETS-1:0]                          lru_q;   // Victim way per set
    logic [cache_pkg::SET_W+cache_pkg::OFFSET_W-1:0]         word_idx;

    assign word_idx = {arr.set, arr.word};    // Flat word index into a way

    // ------------------------------------------------------------------------
    // Control state with reset
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            lru_q   <= '0;                    // Way 0 evicted first
        end else begin
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                if (arr.meta_we[w]) begin
                    valid_q[arr.set][w] <= arr.meta_in.valid;
                end
            end
            if (arr.lru_we) begin
                lru_q[arr.set] <= arr.lru_in;
            end
        end
    end

    assign arr.lru_out = lru_q[arr.set];

    // ------------------------------------------------------------------------
    // Per-way tag and data storage
    // ------------------------------------------------------------------------
    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        logic [cache_pkg::TAG_W-1:0] tag_mem [cache_pkg::NUM_SETS];
        logic [mem_pkg::DATA_W-1:0]  data_mem [cache_pkg::NUM_SETS*cache_pkg::WORDS_PER_BLOCK];

        always_ff @(posedge clk) begin
            if (arr.meta_we[w]) begin
                tag_mem[arr.set] <= arr.meta_in.tag;
            end
            if (arr.data_we[w]) begin
                data_mem[word_idx] <= arr.wdata;   // Single word per write
            end
        end

        assign arr.meta_out[w] = {tag_mem[arr.set], valid_q[arr.set][w]};
        assign arr.data_out[w] = data_mem[word_idx];
    end

endmodule

//--- dcache/dcache_ctrl.sv
// D-cache controller: lookup, LRU, fills and write-through
// The CPU holds mem_read or mem_write and addr until stall is low
// mem_read and mem_write are never high together
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic [mem_pkg::ADDR_W-1:0]     addr,
    input  logic [mem_pkg::DATA_W-1:0]     wdata,
    output logic [mem_pkg::DATA_W-1:0]     rdata,
    output logic                           stall,
    dcache_array_if.ctrl                   arr,
    mem_bus_if.master                      mem,
    output logic                           miss_start,
    input  logic                           fill_busy,
    input  logic                           fill_rd,
    input  logic [mem_pkg::ADDR_W-1:0]     fill_addr,
    input  logic [cache_pkg::OFFSET_W-1:0] fill_word,
    input  logic                           fill_word_we,
    input  logic                           fill_tag_we
);

    logic [cache_pkg::TAG_W-1:0]    req_tag;
    logic                           req;         // Read or write pending
    logic [cache_pkg::NUM_WAYS-1:0] hit_way;
    logic                           hit_idx;     // Encoded hit way
    logic                           hit;
    logic                           miss;
    logic                           victim;      // Way the LRU bit names
    logic                           wt;          // Write-through this cycle

    // ------------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------------
    assign req_tag = addr[mem_pkg::ADDR_W-1:cache_pkg::TAG_LSB];
    assign req     = mem_read | mem_write;
    assign victim  = arr.lru_out;

    always_comb begin
        hit_idx = 1'b0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            hit_way[w] = arr.meta_out[w].valid && (arr.meta_out[w].tag == req_tag);
            if (hit_way[w]) hit_idx = 1'(w);
        end
    end

    assign hit        = req && (|hit_way);
    assign miss       = req && !(|hit_way);
    assign miss_start = miss && !fill_busy;     // First miss cycle only
    assign stall      = miss || fill_busy;
    assign rdata      = (mem_read && hit) ? arr.data_out[hit_idx] : '0;
    assign wt         = mem_write && hit;

    // ------------------------------------------------------------------------
    // Array writes
    // ------------------------------------------------------------------------
    assign arr.set   = addr[cache_pkg::TAG_LSB-1:cache_pkg::SET_LSB];  // Held during fill
    assign arr.word  = fill_word_we ? fill_word : addr[cache_pkg::SET_LSB-1:1];
    assign arr.wdata = fill_word_we ? mem.rdata : wdata;

    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            arr.data_we[w] = (fill_word_we && victim == 1'(w)) || (wt && hit_way[w]);
            arr.meta_we[w] = fill_tag_we && victim == 1'(w);
        end
    end

    assign arr.meta_in = '{tag: req_tag, valid: 1'b1};
    assign arr.lru_we  = fill_tag_we || hit;
    assign arr.lru_in  = fill_tag_we ? ~victim : ~hit_idx;   // Point away from the used way

    // ------------------------------------------------------------------------
    // Memory port, fill read or write-through
    // ------------------------------------------------------------------------
    assign mem.en    = fill_rd || wt;
    assign mem.wr    = wt;
    assign mem.addr  = fill_rd ? fill_addr : addr;
    assign mem.wdata = wdata;

    // Write-through never competes with a block fill
    a_no_wt_in_fill: assert property (@(posedge clk) disable iff (rst)
        mem.en && mem.wr |-> !fill_busy);

endmodule

//--- dcache/dcache_fill_fsm.sv
// Block fill sequencer for the D-cache
// Issues the eight word reads back to back, then counts the returns
// Returns come back in issue order with one rvalid pulse each
`timescale 1ns/10ps

module dcache_fill_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          miss_start,   // One-cycle pulse
    input  logic [mem_pkg::ADDR_W-1:0]    miss_addr,
    input  logic                          rvalid,
    output logic                          busy,
    output logic                          fill_rd,      // Read issue strobe
    output logic [mem_pkg::ADDR_W-1:0]    fill_addr,
    output logic [cache_pkg::OFFSET_W-1:0] fill_word,
    output logic                          word_we,
    output logic                          tag_we
);

    localparam logic [cache_pkg::OFFSET_W-1:0] LAST_WORD =
        cache_pkg::OFFSET_W'(cache_pkg::WORDS_PER_BLOCK - 1);

    cache_pkg::fill_state_e               state;
    logic [mem_pkg::ADDR_W-1:cache_pkg::SET_LSB] block_q;   // Tag and set of the fill
    logic [cache_pkg::OFFSET_W-1:0]       issue_cnt;        // Next word to request
    logic [cache_pkg::OFFSET_W-1:0]       ret_cnt;          // Next word to come back

    // ------------------------------------------------------------------------
    // State and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= cache_pkg::IDLE;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            case (state)
                cache_pkg::IDLE: begin
                    if (miss_start) begin
                        state     <= cache_pkg::FETCH;
                        issue_cnt <= '0;
                        ret_cnt   <= '0;
                    end
                end
                cache_pkg::FETCH: begin
                    issue_cnt <= issue_cnt + 1'b1;
                    if (issue_cnt == LAST_WORD) state <= cache_pkg::DRAIN;
                end
                cache_pkg::DRAIN: begin
                    if (word_we && ret_cnt == LAST_WORD) state <= cache_pkg::COMMIT;
                end
                default: state <= cache_pkg::IDLE;   // COMMIT lasts one cycle
            endcase
            if (word_we) ret_cnt <= ret_cnt + 1'b1;  // Returns overlap FETCH
        end
    end

    // Block base latched on the start pulse
    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && miss_start) begin
            block_q <= miss_addr[mem_pkg::ADDR_W-1:cache_pkg::SET_LSB];
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    assign busy      = (state != cache_pkg::IDLE);
    assign fill_rd   = (state == cache_pkg::FETCH);
    assign fill_addr = {block_q, issue_cnt, 1'b0};          // Word aligned
    assign fill_word = ret_cnt;
    assign word_we   = rvalid && (state == cache_pkg::FETCH || state == cache_pkg::DRAIN);
    assign tag_we    = (state == cache_pkg::COMMIT);

    // All eight words are in before the tag write, so no return is left over
    a_commit_no_rvalid: assert property (@(posedge clk) disable iff (rst)
        state == cache_pkg::COMMIT |-> !rvalid);

    // Memory never returns data nobody asked for
    a_no_idle_rvalid: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> state != cache_pkg::IDLE);

endmodule

//--- design/cache_top.sv
// D-cache subsystem top: controller, arrays, fill FSM and main memory
// CPU inputs must stay stable while stall is high
`timescale 1ns/10ps

module cache_top #(
    parameter int READ_LATENCY = mem_pkg::READ_LATENCY_DEF
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                       stall
);

    mem_bus_if      mem_bus ();
    dcache_array_if arr_bus ();

    // Controller to fill FSM
    logic                           miss_start;
    logic                           fill_busy;
    logic                           fill_rd;
    logic [mem_pkg::ADDR_W-1:0]     fill_addr;
    logic [cache_pkg::OFFSET_W-1:0] fill_word;
    logic                           fill_word_we;
    logic                           fill_tag_we;

    dcache_ctrl ctrl_i (
        .clk, .rst, .mem_read, .mem_write, .addr, .wdata, .rdata, .stall,
        .arr(arr_bus.ctrl), .mem(mem_bus.master),
        .miss_start, .fill_busy, .fill_rd, .fill_addr, .fill_word,
        .fill_word_we, .fill_tag_we
    );

    dcache_arrays arrays_i (.clk, .rst, .arr(arr_bus.array));

    dcache_fill_fsm fill_i (
        .clk, .rst, .miss_start, .miss_addr(addr), .rvalid(mem_bus.rvalid),
        .busy(fill_busy), .fill_rd, .fill_addr, .fill_word,
        .word_we(fill_word_we), .tag_we(fill_tag_we)
    );

    main_memory #(.READ_LATENCY(READ_LATENCY)) memory_i (.clk, .rst, .mem(mem_bus.slave));

endmodule

//--- design/main_memory.sv
// Word-addressed main memory, contents start at zero
// Reads return after READ_LATENCY cycles, one issue per cycle may overlap
// Data is read from the array in the cycle rvalid is high
`timescale 1ns/10ps

module main_memory #(
    parameter int READ_LATENCY = mem_pkg::READ_LATENCY_DEF    // 1 or more
) (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.slave mem
);

    localparam int WADDR_W = mem_pkg::ADDR_W - 1;

    logic [mem_pkg::DATA_W-1:0] mem_array [mem_pkg::MEM_WORDS] = '{default: '0};
    logic [READ_LATENCY-1:0]    vld_pipe;
    logic [WADDR_W-1:0]         addr_pipe [READ_LATENCY];
    logic                       rd_issue;

    if (READ_LATENCY < 1) begin : g_bad_latency
        $error("READ_LATENCY must be at least 1");
    end

    assign rd_issue = mem.en && !mem.wr;

    // Write-through lands the same cycle
    always_ff @(posedge clk) begin
        if (mem.en && mem.wr) begin
            mem_array[mem.addr[mem_pkg::ADDR_W-1:1]] <= mem.wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Read pipeline
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_issue;
            for (int i = 1; i < READ_LATENCY; i++) vld_pipe[i] <= vld_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= mem.addr[mem_pkg::ADDR_W-1:1];
        for (int i = 1; i < READ_LATENCY; i++) addr_pipe[i] <= addr_pipe[i-1];
    end

    assign mem.rvalid = vld_pipe[READ_LATENCY-1];
    assign mem.rdata  = mem_array[addr_pipe[READ_LATENCY-1]];

    a_en_addr_known: assert property (@(posedge clk) disable iff (rst)
        mem.en |-> !$isunknown({mem.wr, mem.addr}));

endmodule

//--- verification/tb_checker.sv
// Reference model of the D-cache: backing memory, tags, valid and LRU per set
// Samples DUT ports on the falling edge, when inputs and outputs are settled
// Assumes the CPU holds each request until stall is seen low
`timescale 1ns/10ps

module tb_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    input  logic [mem_pkg::DATA_W-1:0] rdata,
    input  logic                       stall,
    output int                         stall_errors,
    output int                         data_errors,
    output int                         reqs_done
);

    logic [mem_pkg::DATA_W-1:0]  mem_model [mem_pkg::MEM_WORDS];
    logic [cache_pkg::TAG_W-1:0] tag_model [cache_pkg::NUM_SETS][2];
    logic                        vld_model [cache_pkg::NUM_SETS][2];
    logic                        lru_model [cache_pkg::NUM_SETS];   // Next victim
    logic                        pending;     // Request seen stalled last sample

    // Way holding the tag, or -1 on a miss
    function automatic int find_way(input int s, input logic [cache_pkg::TAG_W-1:0] t);
        int way;
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (vld_model[s][w] && tag_model[s][w] == t) way = w;
        end
        return way;
    endfunction

    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) mem_model[i] = '0;   // Memory starts zeroed
        stall_errors = 0;
        data_errors  = 0;
        reqs_done    = 0;
        pending      = 1'b0;
    end

    // ------------------------------------------------------------------------
    // Per-cycle compare
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : compare
        int                          s;
        int                          way;
        logic [cache_pkg::TAG_W-1:0] t;
        s   = int'(addr[cache_pkg::TAG_LSB-1:cache_pkg::SET_LSB]);
        t   = addr[mem_pkg::ADDR_W-1:cache_pkg::TAG_LSB];
        way = find_way(s, t);
        if (rst) begin
            for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
                vld_model[i] = '{1'b0, 1'b0};
                lru_model[i] = 1'b0;                        // Way 0 evicted first
            end
            pending = 1'b0;
        end else if (!(mem_read || mem_write)) begin
            if (stall !== 1'b0) begin
                stall_errors++;
                $display("FAILED t=%0t: stall %b with no request", $time, stall);
            end
            pending = 1'b0;
        end else begin
            if (!pending && stall !== (way < 0)) begin      // Miss prediction
                stall_errors++;
                $display("FAILED t=%0t: addr %h first cycle stall %b, expected %b",
                         $time, addr, stall, way < 0);
            end
            if (stall === 1'b1) begin
                pending = 1'b1;
                if (rdata !== '0) begin
                    data_errors++;
                    $display("FAILED t=%0t: rdata %h while stalled", $time, rdata);
                end
            end else begin
                pending = 1'b0;
                reqs_done++;
                if (way < 0) begin                          // Fill went to the LRU way
                    way = int'(lru_model[s]);
                    tag_model[s][way] = t;
                    vld_model[s][way] = 1'b1;
                end
                lru_model[s] = (way == 0);                  // Away from the used way
                if (mem_read && rdata !== mem_model[addr[mem_pkg::ADDR_W-1:1]]) begin
                    data_errors++;
                    $display("FAILED t=%0t: read addr %h got %h, expected %h",
                             $time, addr, rdata, mem_model[addr[mem_pkg::ADDR_W-1:1]]);
                end
                if (mem_write) mem_model[addr[mem_pkg::ADDR_W-1:1]] = wdata;
            end
        end
    end

endmodule

//--- verification/tb_clock.sv
// Free-running testbench clock, starts low at time zero
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;   // 50% duty
    end

endmodule

//--- verification/tb_top.sv
// Random read/write test of the D-cache subsystem against tb_checker
// Most addresses come from 4 tags over 4 sets so that evictions are frequent
`timescale 1ns/10ps

module tb_top;

    localparam int READ_LATENCY    = mem_pkg::READ_LATENCY_DEF;
    localparam int NUM_REQS        = 3000;
    localparam int RST_CYCLES      = 16;
    localparam int WATCHDOG_CYCLES = NUM_REQS * (8 + 2 * READ_LATENCY + 20);

    logic                       clk;
    logic                       rst;
    logic                       mem_read;
    logic                       mem_write;
    logic [mem_pkg::ADDR_W-1:0] addr;
    logic [mem_pkg::DATA_W-1:0] wdata;
    logic [mem_pkg::DATA_W-1:0] rdata;
    logic                       stall;
    int                         stall_errors;
    int                         data_errors;
    int                         reqs_done;

    tb_clock clock_i (.clk);

    cache_top #(.READ_LATENCY(READ_LATENCY)) cache_top_i (
        .clk, .rst, .mem_read, .mem_write, .addr, .wdata, .rdata, .stall
    );

    tb_checker checker_i (
        .clk, .rst, .mem_read, .mem_write, .addr, .wdata, .rdata, .stall,
        .stall_errors, .data_errors, .reqs_done
    );

    // 70% of addresses from the pool and the rest anywhere in memory
    function automatic logic [mem_pkg::ADDR_W-1:0] pick_addr();
        logic [5:0] tag;
        logic [5:0] set;
        logic [2:0] word;
        tag  = 6'($urandom_range(3));
        set  = 6'($urandom_range(3) * 9);          // Sets 0, 9, 18, 27
        word = 3'($urandom_range(7));
        if ($urandom_range(99) < 70) return {tag, set, word, 1'b0};
        return 16'($urandom) & 16'hfffe;
    endfunction

    // Hold the request until stall is low at a settled sample point
    task automatic do_request(input logic wr, input logic [15:0] a, input logic [15:0] d);
        mem_read  = !wr;
        mem_write = wr;
        addr      = a;
        wdata     = d;
        @(negedge clk);
        while (stall) @(negedge clk);
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int gap;
        void'($urandom(32'hf840569a));
        rst       = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk);                  // Idle cycles with stall low
        #1;
        for (int n = 0; n < NUM_REQS; n++) begin
            do_request($urandom_range(99) < 40, pick_addr(), 16'($urandom));
            gap = $urandom_range(3);
            repeat (gap) @(posedge clk);
            if (gap > 0) #1;
        end
        repeat (4) @(posedge clk);
        $display("Errors: stall %0d, data %0d, requests %0d", stall_errors, data_errors, reqs_done);
        if (stall_errors == 0 && data_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized for a fill on every request
    initial begin
        repeat (RST_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: requests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- vlog.f
common/mem_pkg.sv
common/cache_pkg.sv
common/mem_bus_if.sv
common/dcache_array_if.sv
dcache/dcache_arrays.sv
dcache/dcache_fill_fsm.sv
dcache/dcache_ctrl.sv
design/main_memory.sv
design/cache_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv
